// ==== Makefile ====
# Verilator build and run of the controller testbench

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -f files.f --top-module tb_top -Mdir obj_dir -o tb_top
	./obj_dir/tb_top | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== files.f ====
logic/ctrl_pkg.sv
logic/ctrl_fsm.sv
logic/hazard_fwd_unit.sv
logic/ctrl_top.sv
tb/ctrl_checker.sv
tb/tb_top.sv

// ==== logic/ctrl_fsm.sv ====
/*
 * main control FSM of the in-order pipeline
 * boot, sleep, decode, pipeline flush and debug handover
 */
`timescale 1ns/100ps

module ctrl_fsm
(
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   fetch_enable_i,
  input  logic                   id_ready_i,
  input  logic                   ex_valid_i,
  input  logic                   branch_taken_ex_i,
  input  logic                   exc_req_i,
  input  logic                   ext_req_i,
  input  logic                   dbg_req_i,
  input  logic                   dbg_stall_i,
  input  logic                   dbg_jump_req_i,
  input  logic                   data_load_event_i,
  input  ctrl_pkg::decode_info_t decode_i,
  input  logic                   jr_stall_i,

  output logic                   ctrl_busy_o,
  output logic                   is_decoding_o,
  output logic                   instr_req_o,
  output logic                   dbg_ack_o,
  output logic                   halt_if_o,
  output logic                   halt_id_o,
  output ctrl_pkg::pc_ctrl_t     pc_o,
  output ctrl_pkg::exc_ctrl_t    exc_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;

  // high once a jump or eret has set the pc, until ID takes the next instr
  logic jump_done_q;
  logic jump_done_d;

  logic is_jump_dec;

  // unconditional jumps are resolved right in ID
  assign is_jump_dec = (decode_i.jump_in_dec == ctrl_pkg::BRANCH_JAL) ||
                       (decode_i.jump_in_dec == ctrl_pkg::BRANCH_JALR);

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////
  always_comb
  begin
    // defaults, core running and fetching
    state_d       = state_q;
    jump_done_d   = jump_done_q;

    ctrl_busy_o   = 1'b1;
    instr_req_o   = 1'b1;
    is_decoding_o = 1'b0;
    dbg_ack_o     = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;

    pc_o.set      = 1'b0;
    pc_o.mux      = ctrl_pkg::PC_BOOT;

    exc_o         = '0;

    case (state_q)
      // idle after reset until fetch is enabled
      ctrl_pkg::RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = ctrl_pkg::BOOT_SET;
        else if (dbg_req_i)
          // debugger may take over before boot, npc not yet valid
          state_d = ctrl_pkg::DBG_SIGNAL;
      end

      // load the boot address into the fetch stage
      ctrl_pkg::BOOT_SET:
      begin
        pc_o.set = 1'b1;
        pc_o.mux = ctrl_pkg::PC_BOOT;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      // pipeline drained and halted, wait for enable or an exception
      ctrl_pkg::SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (dbg_req_i)
        begin
          // remember whether to resume or fall back asleep after debug
          if (fetch_enable_i || exc_req_i)
            state_d = ctrl_pkg::DBG_SIGNAL;
          else
            state_d = ctrl_pkg::DBG_SIGNAL_SLEEP;
        end
        else if (fetch_enable_i || exc_req_i)
        begin
          state_d = ctrl_pkg::FIRST_FETCH;
        end
      end

      // wait for the first instr to reach ID
      ctrl_pkg::FIRST_FETCH:
      begin
        if (id_ready_i && !dbg_stall_i)
          state_d = ctrl_pkg::DECODE;

        // wake-up by exception, nothing in ID yet so save the IF pc
        if (exc_req_i)
        begin
          pc_o.set      = 1'b1;
          pc_o.mux      = ctrl_pkg::PC_EXCEPTION;
          exc_o.ack     = 1'b1;
          exc_o.save_if = 1'b1;
        end
      end

      ctrl_pkg::DECODE:
      begin
        if (branch_taken_ex_i)
        begin
          // taken branch in EX kills the instr in ID
          pc_o.set = 1'b1;
          pc_o.mux = ctrl_pkg::PC_BRANCH;

          // interrupt on a taken branch resumes at the branch target
          if (ext_req_i)
          begin
            pc_o.mux               = ctrl_pkg::PC_EXCEPTION;
            exc_o.ack              = 1'b1;
            exc_o.save_takenbranch = 1'b1;
            halt_id_o              = 1'b1;
          end

          if (dbg_req_i)
            state_d = ctrl_pkg::DBG_SIGNAL;
        end
        else if (decode_i.instr_valid)
        begin
          is_decoding_o = 1'b1;

          if (is_jump_dec)
          begin
            pc_o.mux = ctrl_pkg::PC_JUMP;
            // target needs rs1, hold off while it is still in flight
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_o.set    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            // keep the faulting instr out of EX
            pc_o.set      = 1'b1;
            pc_o.mux      = ctrl_pkg::PC_EXCEPTION;
            exc_o.ack     = 1'b1;
            exc_o.save_id = 1'b1;
            halt_id_o     = 1'b1;
          end

          if (decode_i.eret)
          begin
            pc_o.mux         = ctrl_pkg::PC_ERET;
            exc_o.restore_id = 1'b1;
            if (!jump_done_q)
            begin
              pc_o.set    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // wfi, or eret back into sleep, drains the pipeline
          if (decode_i.pipe_flush || (decode_i.eret && !fetch_enable_i))
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
          else if (dbg_req_i)
          begin
            halt_if_o = 1'b1;
            // let the instr in ID move on first
            if (id_ready_i)
            begin
              if (decode_i.jump_in_id == ctrl_pkg::BRANCH_COND)
                state_d = ctrl_pkg::DBG_WAIT_BRANCH;
              else
                state_d = ctrl_pkg::DBG_SIGNAL;
            end
            else if (data_load_event_i)
            begin
              // event load blocks ID indefinitely, enter debug anyway
              state_d = ctrl_pkg::DBG_SIGNAL;
            end
          end
        end
        else if (ext_req_i)
        begin
          // bubble in ID, resume at the fetch pc
          pc_o.set      = 1'b1;
          pc_o.mux      = ctrl_pkg::PC_EXCEPTION;
          exc_o.ack     = 1'b1;
          exc_o.save_if = 1'b1;
          halt_id_o     = 1'b1;
        end
      end

      // conditional branch resolves in EX before debug takes over
      ctrl_pkg::DBG_WAIT_BRANCH:
      begin
        halt_if_o = 1'b1;
        if (branch_taken_ex_i)
        begin
          pc_o.set = 1'b1;
          pc_o.mux = ctrl_pkg::PC_BRANCH;
        end
        state_d = ctrl_pkg::DBG_SIGNAL;
      end

      // pipeline is empty, hand over to the debugger
      ctrl_pkg::DBG_SIGNAL:
      begin
        dbg_ack_o = 1'b1;
        halt_if_o = 1'b1;
        state_d   = ctrl_pkg::DBG_WAIT;
      end

      ctrl_pkg::DBG_SIGNAL_SLEEP:
      begin
        dbg_ack_o = 1'b1;
        halt_if_o = 1'b1;
        state_d   = ctrl_pkg::DBG_WAIT_SLEEP;
      end

      // debugger owns the core, return to sleep when released
      ctrl_pkg::DBG_WAIT_SLEEP:
      begin
        halt_if_o = 1'b1;
        if (dbg_jump_req_i)
        begin
          pc_o.set = 1'b1;
          pc_o.mux = ctrl_pkg::PC_DBG_NPC;
          state_d  = ctrl_pkg::DBG_WAIT;
        end
        if (!dbg_stall_i)
          state_d = ctrl_pkg::SLEEP;
      end

      // debugger owns the core, return to decode when released
      ctrl_pkg::DBG_WAIT:
      begin
        halt_if_o = 1'b1;
        if (dbg_jump_req_i)
        begin
          pc_o.set = 1'b1;
          pc_o.mux = ctrl_pkg::PC_DBG_NPC;
        end
        if (!dbg_stall_i)
          state_d = ctrl_pkg::DECODE;
      end

      // nop into EX until the last instr leaves it
      ctrl_pkg::FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = ctrl_pkg::FLUSH_WB;
      end

      // WB drained too, pick sleep, decode or debug
      ctrl_pkg::FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i)
        begin
          if (dbg_req_i)
          begin
            state_d = ctrl_pkg::DBG_SIGNAL;
          end
          else
          begin
            halt_if_o = 1'b0;
            state_d   = ctrl_pkg::DECODE;
          end
        end
        else if (dbg_req_i)
        begin
          state_d = ctrl_pkg::DBG_SIGNAL_SLEEP;
        end
        else
        begin
          state_d = ctrl_pkg::SLEEP;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////////////////////////
  // state registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // ID accepting means the jump target is the next instr
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

// ==== logic/ctrl_pkg.sv ====
/*
 * shared types for the pipeline controller
 * state and select encodings plus the port structs between the units
 */
package ctrl_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int STATE_W   = 4;
  localparam int PC_MUX_W  = 3;
  localparam int JUMP_W    = 2;
  localparam int FWD_SEL_W = 2;

  // controller states, one clock per step
  typedef enum logic [STATE_W-1:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB,
    DBG_SIGNAL,
    DBG_SIGNAL_SLEEP,
    DBG_WAIT,
    DBG_WAIT_BRANCH,
    DBG_WAIT_SLEEP
  } ctrl_state_e;

  // next pc source in the fetch stage
  typedef enum logic [PC_MUX_W-1:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101,
    PC_DBG_NPC   = 3'b111
  } pc_mux_e;

  // kind of control transfer seen by the decoder
  typedef enum logic [JUMP_W-1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_e;

  // operand source in ID
  typedef enum logic [FWD_SEL_W-1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_e;

  ////////////////////////////////////////
  // port structs
  ////////////////////////////////////////

  // decoder view of the instruction in ID
  typedef struct packed {
    logic       illegal;
    logic       eret;
    logic       pipe_flush;
    logic       instr_valid;
    jump_kind_e jump_in_dec;
    jump_kind_e jump_in_id;
  } decode_info_t;

  // write enables and register match bits from regfile and pipeline
  typedef struct packed {
    logic data_req_ex;
    logic we_ex;
    logic we_wb;
    logic alu_we;
    logic wb_is_a;
    logic wb_is_b;
    logic alu_is_a;
    logic alu_is_b;
  } reg_hazard_t;

  // pc update request to the prefetcher
  typedef struct packed {
    logic    set;
    pc_mux_e mux;
  } pc_ctrl_t;

  // exception controller handshake and save controls
  typedef struct packed {
    logic ack;
    logic save_if;
    logic save_id;
    logic save_takenbranch;
    logic restore_id;
  } exc_ctrl_t;

  typedef struct packed {
    logic halt_if;
    logic halt_id;
    logic jr_stall;
    logic load_stall;
    logic deassert_we;
  } stall_t;

  typedef struct packed {
    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
  } fwd_ctrl_t;

  // single cycle event pulses for the counters
  typedef struct packed {
    logic jump;
    logic jr_stall;
    logic ld_stall;
  } perf_t;

endpackage

// ==== logic/ctrl_top.sv ====
/*
 * pipeline controller top
 * joins the control FSM with the hazard unit, forms the perf pulses
 */
`timescale 1ns/100ps

module ctrl_top
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  fetch_enable_i,
  input  logic                  id_ready_i,
  input  logic                  ex_valid_i,
  input  logic                  branch_taken_ex_i,
  input  logic                  exc_req_i,
  input  logic                  ext_req_i,
  input  logic                  dbg_req_i,
  input  logic                  dbg_stall_i,
  input  logic                  dbg_jump_req_i,
  input  logic                  data_load_event_i,
  input  ctrl_pkg::decode_info_t decode_i,
  input  ctrl_pkg::reg_hazard_t hazard_i,

  output logic                  ctrl_busy_o,
  output logic                  is_decoding_o,
  output logic                  instr_req_o,
  output logic                  dbg_ack_o,
  output ctrl_pkg::pc_ctrl_t    pc_o,
  output ctrl_pkg::exc_ctrl_t   exc_o,
  output ctrl_pkg::stall_t      stall_o,
  output ctrl_pkg::fwd_ctrl_t   fwd_o,
  output ctrl_pkg::perf_t       perf_o
);

  logic is_decoding;
  logic jr_stall;
  logic load_stall;
  logic deassert_we;
  logic halt_if;
  logic halt_id;

  ctrl_fsm u_fsm
  (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .exc_req_i         (exc_req_i),
    .ext_req_i         (ext_req_i),
    .dbg_req_i         (dbg_req_i),
    .dbg_stall_i       (dbg_stall_i),
    .dbg_jump_req_i    (dbg_jump_req_i),
    .data_load_event_i (data_load_event_i),
    .decode_i          (decode_i),
    .jr_stall_i        (jr_stall),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding),
    .instr_req_o       (instr_req_o),
    .dbg_ack_o         (dbg_ack_o),
    .halt_if_o         (halt_if),
    .halt_id_o         (halt_id),
    .pc_o              (pc_o),
    .exc_o             (exc_o)
  );

  // jr_stall only looks at decode and match bits, so no comb loop
  hazard_fwd_unit u_hazard
  (
    .is_decoding_i (is_decoding),
    .illegal_i     (decode_i.illegal),
    .jump_in_dec_i (decode_i.jump_in_dec),
    .hazard_i      (hazard_i),
    .load_stall_o  (load_stall),
    .jr_stall_o    (jr_stall),
    .deassert_we_o (deassert_we),
    .fwd_o         (fwd_o)
  );

  assign is_decoding_o = is_decoding;

  // stall bundle to the pipeline
  assign stall_o.halt_if     = halt_if;
  assign stall_o.halt_id     = halt_id;
  assign stall_o.jr_stall    = jr_stall;
  assign stall_o.load_stall  = load_stall;
  assign stall_o.deassert_we = deassert_we;

  // counter events, a jump is any unconditional jump sitting in ID
  assign perf_o.jump     = (decode_i.jump_in_id == ctrl_pkg::BRANCH_JAL) ||
                           (decode_i.jump_in_id == ctrl_pkg::BRANCH_JALR);
  assign perf_o.jr_stall = jr_stall;
  assign perf_o.ld_stall = load_stall;

endmodule

// ==== logic/hazard_fwd_unit.sv ====
/*
 * hazard and forwarding unit
 * load-use and jump-register stalls, write-enable kill, operand selects
 */
`timescale 1ns/100ps

module hazard_fwd_unit
(
  input  logic                  is_decoding_i,
  input  logic                  illegal_i,
  input  ctrl_pkg::jump_kind_e  jump_in_dec_i,
  input  ctrl_pkg::reg_hazard_t hazard_i,

  output logic                  load_stall_o,
  output logic                  jr_stall_o,
  output logic                  deassert_we_o,
  output ctrl_pkg::fwd_ctrl_t   fwd_o
);

  logic rs1_pending;

  ////////////////////////////////////////
  // stalls
  ////////////////////////////////////////

  // load in EX writes a register that ID reads
  assign load_stall_o = hazard_i.data_req_ex && hazard_i.we_ex &&
                        (hazard_i.alu_is_a || hazard_i.alu_is_b);

  // rs1 of ID still waits on a write from WB, EX or the ALU path
  assign rs1_pending = (hazard_i.we_wb  && hazard_i.wb_is_a)  ||
                       (hazard_i.we_ex  && hazard_i.alu_is_a) ||
                       (hazard_i.alu_we && hazard_i.alu_is_a);

  // jalr target comes straight from rs1, no forwarding into the pc path
  assign jr_stall_o = (jump_in_dec_i == ctrl_pkg::BRANCH_JALR) && rs1_pending;

  // nothing from ID may write back unless it is a legal instr that moves on
  assign deassert_we_o = !is_decoding_i || illegal_i || load_stall_o || jr_stall_o;

  ////////////////////////////////////////
  // forwarding selects
  ////////////////////////////////////////
  always_comb
  begin
    fwd_o.sel_a = ctrl_pkg::SEL_REGFILE;
    fwd_o.sel_b = ctrl_pkg::SEL_REGFILE;

    // WB to ID
    if (hazard_i.we_wb)
    begin
      if (hazard_i.wb_is_a)
        fwd_o.sel_a = ctrl_pkg::SEL_FW_WB;
      if (hazard_i.wb_is_b)
        fwd_o.sel_b = ctrl_pkg::SEL_FW_WB;
    end

    // EX to ID, younger result so it overrides WB
    if (hazard_i.alu_we)
    begin
      if (hazard_i.alu_is_a)
        fwd_o.sel_a = ctrl_pkg::SEL_FW_EX;
      if (hazard_i.alu_is_b)
        fwd_o.sel_b = ctrl_pkg::SEL_FW_EX;
    end
  end

endmodule

// ==== tb/ctrl_checker.sv ====
/*
 * output checker for the controller testbench
 * compares DUT outputs with the expected row late in each cycle
 */
`timescale 1ns/100ps

module ctrl_checker
#(
  parameter int NAME_W = 128
)
(
  input  logic                   clk,
  input  logic                   strobe_i,
  input  logic                   done_i,
  input  int                     test_i,
  input  logic [NAME_W-1:0]      name_i,

  // expected values of the current row
  input  logic                   exp_busy_i,
  input  logic                   exp_decoding_i,
  input  logic                   exp_instr_req_i,
  input  logic                   exp_dbg_ack_i,
  input  ctrl_pkg::pc_ctrl_t     exp_pc_i,
  input  ctrl_pkg::exc_ctrl_t    exp_exc_i,
  input  ctrl_pkg::stall_t       exp_stall_i,
  input  ctrl_pkg::fwd_ctrl_t    exp_fwd_i,
  input  ctrl_pkg::perf_t        exp_perf_i,

  // DUT outputs as seen on the top level
  input  logic                   busy_i,
  input  logic                   decoding_i,
  input  logic                   instr_req_i,
  input  logic                   dbg_ack_i,
  input  ctrl_pkg::pc_ctrl_t     pc_i,
  input  ctrl_pkg::exc_ctrl_t    exc_i,
  input  ctrl_pkg::stall_t       stall_i,
  input  ctrl_pkg::fwd_ctrl_t    fwd_i,
  input  ctrl_pkg::perf_t        perf_i,

  output int                     checked_o,
  output int                     fails_o
);

  // just before the next rising edge, comb outputs have long settled
  localparam int SAMPLE_DLY = 36;

  int checked;
  int fails;
  int mismatches;

  // one compare, widened to a byte so every field fits
  task automatic check_sig(input string sig, input logic [7:0] exp_v, input logic [7:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("[ERROR] %0d ns %s expected %h actual %h", $time, sig, exp_v, act_v);
      mismatches++;
    end
  endtask

  ////////////////////////////////////////
  // per row compare
  ////////////////////////////////////////
  always @(posedge clk)
  begin
    #(SAMPLE_DLY);
    if (strobe_i)
    begin
      mismatches = 0;
      check_sig("ctrl_busy_o", 8'(exp_busy_i), 8'(busy_i));
      check_sig("is_decoding_o", 8'(exp_decoding_i), 8'(decoding_i));
      check_sig("instr_req_o", 8'(exp_instr_req_i), 8'(instr_req_i));
      check_sig("dbg_ack_o", 8'(exp_dbg_ack_i), 8'(dbg_ack_i));
      check_sig("pc_o", 8'(exp_pc_i), 8'(pc_i));
      check_sig("exc_o", 8'(exp_exc_i), 8'(exc_i));
      check_sig("stall_o", 8'(exp_stall_i), 8'(stall_i));
      check_sig("fwd_o", 8'(exp_fwd_i), 8'(fwd_i));
      check_sig("perf_o", 8'(exp_perf_i), 8'(perf_i));
      checked++;
      if (mismatches == 0)
      begin
        $display("test %0d %s ok", test_i, name_i);
      end
      else
      begin
        fails++;
        $display("test %0d %s failed with %0d mismatches", test_i, name_i, mismatches);
      end
    end
  end

  // closing summary
  always @(posedge done_i)
    $display("tests checked %0d, passed %0d, failed %0d", checked, checked - fails, fails);

  assign checked_o = checked;
  assign fails_o   = fails;

endmodule

// ==== tb/tb_top.sv ====
/*
 * testbench for the pipeline controller
 * applies a table of input rows and expected outputs, one row per clock
 */
`timescale 1ns/100ps

module tb_top;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 16;
  localparam int DRV_DLY     = 2;
  localparam int WDOG_MARGIN = 10;
  localparam int N_RAND      = 12;
  localparam int SEED        = 62795;
  localparam int NAME_W      = 128;

  // all DUT inputs of one cycle
  typedef struct packed {
    logic                   fetch_enable;
    logic                   id_ready;
    logic                   ex_valid;
    logic                   branch_taken;
    logic                   exc_req;
    logic                   ext_req;
    logic                   dbg_req;
    logic                   dbg_stall;
    logic                   dbg_jump_req;
    logic                   data_load_event;
    ctrl_pkg::decode_info_t decode;
    ctrl_pkg::reg_hazard_t  hazard;
  } stim_t;

  // all DUT outputs of one cycle
  typedef struct packed {
    logic                busy;
    logic                is_decoding;
    logic                instr_req;
    logic                dbg_ack;
    ctrl_pkg::pc_ctrl_t  pc;
    ctrl_pkg::exc_ctrl_t exc;
    ctrl_pkg::stall_t    stall;
    ctrl_pkg::fwd_ctrl_t fwd;
    ctrl_pkg::perf_t     perf;
  } exp_t;

  logic              clk;
  logic              rst_n;
  stim_t             stim;
  exp_t              expv;
  logic              strobe;
  logic              done;
  int                test_idx;
  logic [NAME_W-1:0] test_name;
  int                table_len;

  // the table, filled at time zero
  stim_t             stim_q[$];
  exp_t              exp_q[$];
  logic [NAME_W-1:0] name_q[$];

  // row under construction
  stim_t s;
  exp_t  e;

  logic                busy;
  logic                decoding;
  logic                instr_req;
  logic                dbg_ack;
  ctrl_pkg::pc_ctrl_t  pc;
  ctrl_pkg::exc_ctrl_t exc;
  ctrl_pkg::stall_t    stall;
  ctrl_pkg::fwd_ctrl_t fwd;
  ctrl_pkg::perf_t     perf;
  int                  checked;
  int                  fails;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ctrl_top u_dut
  (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (stim.fetch_enable),
    .id_ready_i        (stim.id_ready),
    .ex_valid_i        (stim.ex_valid),
    .branch_taken_ex_i (stim.branch_taken),
    .exc_req_i         (stim.exc_req),
    .ext_req_i         (stim.ext_req),
    .dbg_req_i         (stim.dbg_req),
    .dbg_stall_i       (stim.dbg_stall),
    .dbg_jump_req_i    (stim.dbg_jump_req),
    .data_load_event_i (stim.data_load_event),
    .decode_i          (stim.decode),
    .hazard_i          (stim.hazard),
    .ctrl_busy_o       (busy),
    .is_decoding_o     (decoding),
    .instr_req_o       (instr_req),
    .dbg_ack_o         (dbg_ack),
    .pc_o              (pc),
    .exc_o             (exc),
    .stall_o           (stall),
    .fwd_o             (fwd),
    .perf_o            (perf)
  );

  ctrl_checker #(.NAME_W(NAME_W)) u_chk
  (
    .clk             (clk),
    .strobe_i        (strobe),
    .done_i          (done),
    .test_i          (test_idx),
    .name_i          (test_name),
    .exp_busy_i      (expv.busy),
    .exp_decoding_i  (expv.is_decoding),
    .exp_instr_req_i (expv.instr_req),
    .exp_dbg_ack_i   (expv.dbg_ack),
    .exp_pc_i        (expv.pc),
    .exp_exc_i       (expv.exc),
    .exp_stall_i     (expv.stall),
    .exp_fwd_i       (expv.fwd),
    .exp_perf_i      (expv.perf),
    .busy_i          (busy),
    .decoding_i      (decoding),
    .instr_req_i     (instr_req),
    .dbg_ack_i       (dbg_ack),
    .pc_i            (pc),
    .exc_i           (exc),
    .stall_i         (stall),
    .fwd_i           (fwd),
    .perf_i          (perf),
    .checked_o       (checked),
    .fails_o         (fails)
  );

  ////////////////////////////////////////
  // expected values from the hazard rules
  ////////////////////////////////////////

  // EX result is younger than WB, so it wins
  function automatic ctrl_pkg::fwd_sel_e fwd_pick(input logic ex_hit, input logic wb_hit);
    if (ex_hit)
      return ctrl_pkg::SEL_FW_EX;
    if (wb_hit)
      return ctrl_pkg::SEL_FW_WB;
    return ctrl_pkg::SEL_REGFILE;
  endfunction

  function automatic exp_t predict_hazard(input stim_t st, input exp_t ex);
    exp_t                  r;
    logic                  a_pending;
    ctrl_pkg::reg_hazard_t h;
    r = ex;
    h = st.hazard;
    r.stall.load_stall = h.data_req_ex & h.we_ex & (h.alu_is_a | h.alu_is_b);
    // pending writes to operand A from WB, EX or ALU
    a_pending = (h.we_wb & h.wb_is_a) | (h.we_ex & h.alu_is_a) | (h.alu_we & h.alu_is_a);
    r.stall.jr_stall = (st.decode.jump_in_dec == ctrl_pkg::BRANCH_JALR) & a_pending;
    r.stall.deassert_we = ~ex.is_decoding | st.decode.illegal |
                          r.stall.load_stall | r.stall.jr_stall;
    r.fwd.sel_a = fwd_pick(h.alu_we & h.alu_is_a, h.we_wb & h.wb_is_a);
    r.fwd.sel_b = fwd_pick(h.alu_we & h.alu_is_b, h.we_wb & h.wb_is_b);
    r.perf.jump = (st.decode.jump_in_id == ctrl_pkg::BRANCH_JAL) |
                  (st.decode.jump_in_id == ctrl_pkg::BRANCH_JALR);
    r.perf.jr_stall = r.stall.jr_stall;
    r.perf.ld_stall = r.stall.load_stall;
    return r;
  endfunction

  function automatic ctrl_pkg::jump_kind_e rand_kind();
    int unsigned r;
    r = $urandom % 4;
    case (r)
      0:       return ctrl_pkg::BRANCH_NONE;
      1:       return ctrl_pkg::BRANCH_JAL;
      2:       return ctrl_pkg::BRANCH_JALR;
      default: return ctrl_pkg::BRANCH_COND;
    endcase
  endfunction

  ////////////////////////////////////////
  // table building
  ////////////////////////////////////////

  // running core, fetch enabled, ID ready, nothing pending
  task start_row();
    s              = '0;
    s.fetch_enable = 1'b1;
    s.id_ready     = 1'b1;
    e              = '0;
    e.busy         = 1'b1;
    e.instr_req    = 1'b1;
  endtask

  task add_row(input logic [NAME_W-1:0] name);
    e = predict_hazard(s, e);
    stim_q.push_back(s);
    exp_q.push_back(e);
    name_q.push_back(name);
  endtask

  // plain decode cycle, an unconditional jump sets the pc unless rs1 is pending
  task add_decode_row(input logic [NAME_W-1:0] name);
    s.decode.instr_valid = 1'b1;
    e.is_decoding        = 1'b1;
    e = predict_hazard(s, e);
    if (s.decode.jump_in_dec == ctrl_pkg::BRANCH_JAL ||
        s.decode.jump_in_dec == ctrl_pkg::BRANCH_JALR)
    begin
      e.pc.mux = ctrl_pkg::PC_JUMP;
      e.pc.set = ~e.stall.jr_stall;
    end
    add_row(name);
  endtask

  task add_jal_row(input logic [NAME_W-1:0] name, input logic rdy, input logic set);
    start_row();
    s.id_ready           = rdy;
    s.decode.instr_valid = 1'b1;
    s.decode.jump_in_dec = ctrl_pkg::BRANCH_JAL;
    s.decode.jump_in_id  = ctrl_pkg::BRANCH_JAL;
    e.is_decoding        = 1'b1;
    e.pc.mux             = ctrl_pkg::PC_JUMP;
    e.pc.set             = set;
    add_row(name);
  endtask

  task build_table();
    int k;
    // boot
    start_row();
    s.fetch_enable = 1'b0;
    e.busy         = 1'b0;
    e.instr_req    = 1'b0;
    add_row("reset_idle");
    start_row();
    e.busy      = 1'b0;
    e.instr_req = 1'b0;
    add_row("reset_fetch_en");
    start_row();
    e.pc.set = 1'b1;
    e.pc.mux = ctrl_pkg::PC_BOOT;
    add_row("boot_set");
    start_row();
    add_row("first_fetch");
    start_row();
    add_decode_row("decode_valid");
    start_row();
    add_row("decode_bubble");

    // fixed hazard and forwarding rows
    start_row();
    s.hazard.we_wb   = 1'b1;
    s.hazard.wb_is_a = 1'b1;
    add_decode_row("fwd_wb_a");
    start_row();
    s.hazard.we_wb    = 1'b1;
    s.hazard.alu_we   = 1'b1;
    s.hazard.wb_is_a  = 1'b1;
    s.hazard.wb_is_b  = 1'b1;
    s.hazard.alu_is_a = 1'b1;
    add_decode_row("fwd_ex_over_wb");
    start_row();
    s.hazard.data_req_ex = 1'b1;
    s.hazard.we_ex       = 1'b1;
    s.hazard.alu_is_b    = 1'b1;
    add_decode_row("load_use_b");
    start_row();
    s.decode.jump_in_dec = ctrl_pkg::BRANCH_JALR;
    s.hazard.we_ex       = 1'b1;
    s.hazard.alu_is_a    = 1'b1;
    add_decode_row("jalr_stall");
    start_row();
    s.decode.jump_in_dec = ctrl_pkg::BRANCH_JALR;
    s.hazard.we_wb       = 1'b1;
    s.hazard.wb_is_b     = 1'b1;
    add_decode_row("jalr_free");
    start_row();
    s.decode.illegal = 1'b1;
    add_decode_row("illegal_kill");

    // random match bits and jump kinds, ID always ready
    for (k = 0; k < N_RAND; k++)
    begin
      start_row();
      s.hazard             = 8'($urandom);
      s.decode.illegal     = 1'($urandom);
      s.decode.jump_in_dec = rand_kind();
      s.decode.jump_in_id  = rand_kind();
      add_decode_row("random_hazard");
    end

    // taken branch, then taken branch with an interrupt
    start_row();
    s.branch_taken       = 1'b1;
    s.decode.instr_valid = 1'b1;
    e.pc.set             = 1'b1;
    e.pc.mux             = ctrl_pkg::PC_BRANCH;
    add_row("branch_taken");
    start_row();
    s.branch_taken         = 1'b1;
    s.ext_req              = 1'b1;
    s.decode.instr_valid   = 1'b1;
    e.pc.set               = 1'b1;
    e.pc.mux               = ctrl_pkg::PC_EXCEPTION;
    e.exc.ack              = 1'b1;
    e.exc.save_takenbranch = 1'b1;
    e.stall.halt_id        = 1'b1;
    add_row("branch_irq");

    // jal with ID stalled, one pc set only
    add_jal_row("jal_issue", 1'b0, 1'b1);
    add_jal_row("jal_hold", 1'b0, 1'b0);
    add_jal_row("jal_hold_2", 1'b0, 1'b0);
    add_jal_row("jal_accept", 1'b1, 1'b0);
    start_row();
    add_decode_row("after_jump");

    // debug entry, npc jump and release
    start_row();
    s.dbg_req            = 1'b1;
    s.decode.instr_valid = 1'b1;
    e.is_decoding        = 1'b1;
    e.stall.halt_if      = 1'b1;
    add_row("dbg_request");
    start_row();
    s.dbg_req       = 1'b1;
    s.dbg_stall     = 1'b1;
    e.dbg_ack       = 1'b1;
    e.stall.halt_if = 1'b1;
    add_row("dbg_ack");
    start_row();
    s.dbg_stall     = 1'b1;
    s.dbg_jump_req  = 1'b1;
    e.stall.halt_if = 1'b1;
    e.pc.set        = 1'b1;
    e.pc.mux        = ctrl_pkg::PC_DBG_NPC;
    add_row("dbg_jump");
    start_row();
    s.dbg_stall     = 1'b1;
    e.stall.halt_if = 1'b1;
    add_row("dbg_wait");
    start_row();
    e.stall.halt_if = 1'b1;
    add_row("dbg_release");
    start_row();
    add_decode_row("dbg_resumed");

    // wfi drains the pipeline, sleep, exception wakes the core
    start_row();
    s.decode.instr_valid = 1'b1;
    s.decode.pipe_flush  = 1'b1;
    e.is_decoding        = 1'b1;
    e.stall.halt_if      = 1'b1;
    e.stall.halt_id      = 1'b1;
    add_row("wfi_flush");
    start_row();
    s.fetch_enable  = 1'b0;
    e.stall.halt_if = 1'b1;
    e.stall.halt_id = 1'b1;
    add_row("flush_ex_wait");
    start_row();
    s.fetch_enable  = 1'b0;
    s.ex_valid      = 1'b1;
    e.stall.halt_if = 1'b1;
    e.stall.halt_id = 1'b1;
    add_row("flush_ex_done");
    start_row();
    s.fetch_enable  = 1'b0;
    e.stall.halt_if = 1'b1;
    e.stall.halt_id = 1'b1;
    add_row("flush_wb");
    start_row();
    s.fetch_enable  = 1'b0;
    e.busy          = 1'b0;
    e.instr_req     = 1'b0;
    e.stall.halt_if = 1'b1;
    e.stall.halt_id = 1'b1;
    add_row("sleep");
    start_row();
    s.fetch_enable  = 1'b0;
    s.exc_req       = 1'b1;
    e.busy          = 1'b0;
    e.instr_req     = 1'b0;
    e.stall.halt_if = 1'b1;
    e.stall.halt_id = 1'b1;
    add_row("wake_exc");
    start_row();
    s.fetch_enable = 1'b0;
    s.exc_req      = 1'b1;
    e.pc.set       = 1'b1;
    e.pc.mux       = ctrl_pkg::PC_EXCEPTION;
    e.exc.ack      = 1'b1;
    e.exc.save_if  = 1'b1;
    add_row("wake_first_fetch");
    start_row();
    add_decode_row("wake_decode");
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial
  begin
    int i;
    rst_n     = 1'b0;
    stim      = '0;
    expv      = '0;
    strobe    = 1'b0;
    done      = 1'b0;
    test_idx  = 0;
    test_name = '0;
    table_len = 0;
    void'($urandom(SEED));
    build_table();
    table_len = stim_q.size();

    repeat (RST_CYCLES) @(posedge clk);
    #(DRV_DLY);
    rst_n = 1'b1;

    // one row per cycle, driven shortly after the edge
    for (i = 0; i < table_len; i++)
    begin
      @(posedge clk);
      #(DRV_DLY);
      stim      = stim_q[i];
      expv      = exp_q[i];
      test_name = name_q[i];
      test_idx  = i;
      strobe    = 1'b1;
    end
    @(posedge clk);
    #(DRV_DLY);
    strobe = 1'b0;
    stim   = '0;

    @(posedge clk);
    done = 1'b1;
    #1;
    if (fails == 0 && checked == table_len)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      if (checked != table_len)
        $display("only %0d of %0d rows were compared", checked, table_len);
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // bound from the table length plus reset
  initial
  begin
    wait (table_len > 0);
    #((table_len + RST_CYCLES + WDOG_MARGIN) * CLK_PERIOD);
    $display("watchdog expired before the table was applied");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
